// File: compile.f
logic/synth_cfg_pkg.sv
logic/osc_pkg.sv
logic/slot_sequencer.sv
logic/slot_config.sv
logic/nco_ram.sv
logic/nco_phase.sv
logic/wave_shaper.sv
logic/voice_mixer.sv
logic/synth_osc_top.sv
dv/tb_clock.sv
dv/tb_synth_osc.sv

// File: dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 10
) (
    output logic sCLK_XVXENVS
);

    initial begin
        sCLK_XVXENVS = 1'b0;
        forever begin
            #(PERIOD / 2) sCLK_XVXENVS = ~sCLK_XVXENVS;
        end
    end

endmodule

// File: dv/tb_synth_osc.sv
`timescale 1ns/1ns

module tb_synth_osc;

    localparam int VOICES = 8;
    localparam int V_OSC  = 4;
    localparam int N      = VOICES * V_OSC;
    localparam int CLK_NS = 10;

    logic                sCLK_XVXENVS;
    logic                reset;
    osc_pkg::cfg_wr_t    cfg_wr;
    synth_cfg_pkg::mix_t mix_sample;
    logic                sample_valid;

    logic [25:0] acc_m     [N];  // model accumulators
    logic [23:0] act_pitch [N];  // config of the frame whose sample comes next
    logic [1:0]  act_wave  [N];
    logic        act_key   [N];
    logic [23:0] sh_pitch  [N];  // host side, latched at frame start
    logic [1:0]  sh_wave   [N];
    logic        sh_key    [N];
    int          errors;
    int          checks;
    time         last_t;
    bit          have_last;

    tb_clock #(.PERIOD(CLK_NS)) u_tb_clock (.sCLK_XVXENVS(sCLK_XVXENVS));

    synth_osc_top #(.VOICES(VOICES), .V_OSC(V_OSC)) u_synth_osc_top (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cfg_wr       (cfg_wr),
        .mix_sample   (mix_sample),
        .sample_valid (sample_valid)
    );

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // waveform rules, p unsigned 0..2047
    function automatic int shape(logic [1:0] w, logic [10:0] p);
        int pu;
        int q;
        pu = int'(p);
        q  = pu % 1024;
        case (w)
            2'd1: return pu - 1024;
            2'd2: return (pu < 1024) ? 1023 : -1024;
            2'd3: return (pu < 1024) ? (2 * q - 1024) : (1023 - 2 * q);
            default: return 0;
        endcase
    endfunction

    // one frame of the model, then latch the host table for the next one
    function automatic int model_frame();
        int          sum;
        logic [25:0] pres;
        sum = 0;
        for (int i = 0; i < N; i++) begin
            pres     = act_key[i] ? 26'd0 : acc_m[i];
            sum     += shape(act_wave[i], pres[24:14]);
            acc_m[i] = pres + {2'b00, act_pitch[i]};  // wraps mod 2^26
            act_pitch[i] = sh_pitch[i];
            act_wave[i]  = sh_wave[i];
            act_key[i]   = sh_key[i];
            sh_key[i]    = 1'b0;
        end
        return sum;
    endfunction

    // outputs looked at on the falling edge, return on a rising edge
    task automatic wait_sample();
        int n;
        bit seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 4 * N) begin
            @(negedge sCLK_XVXENVS);
            n++;
            if (sample_valid === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout: no sample_valid within %0d cycles", 4 * N);
            $display("errors: %0d, checks: %0d", errors, checks);
            $display("Simulation failed");
            $finish;
        end else begin
            @(posedge sCLK_XVXENVS);
        end
    endtask

    task automatic next_frame(output int mix_val);
        int exp;
        wait_sample();
        exp     = model_frame();
        mix_val = int'(mix_sample);
        check_value("mix_sample", 32'(mix_sample), 32'(exp));
        if (have_last) begin
            check_value("sample_valid period", 32'(($time - last_t) / CLK_NS), 32'(N));
        end
        have_last = 1'b1;
        last_t    = $time;
    endtask

    task automatic host_write(int idx, logic [23:0] pitch, logic [1:0] w, logic key);
        osc_pkg::cfg_wr_t wr;
        wr.valid      = 1'b1;
        wr.slot.voice = synth_cfg_pkg::voice_t'(idx / V_OSC);
        wr.slot.osc   = synth_cfg_pkg::osc_t'(idx % V_OSC);  // osc fastest
        wr.pitch      = pitch;
        wr.wave       = osc_pkg::wave_e'(w);
        wr.key_on     = key;
        cfg_wr       <= wr;
        sh_pitch[idx] = pitch;
        sh_wave[idx]  = w;
        sh_key[idx]   = sh_key[idx] | key;  // sticky until latched
        @(posedge sCLK_XVXENVS);
    endtask

    task automatic end_writes();
        cfg_wr <= '0;
    endtask

    task automatic random_writes(int count);
        for (int i = 0; i < count; i++) begin
            host_write(int'($urandom % N), 24'($urandom), 2'($urandom), ($urandom % 8) == 0);
        end
        end_writes();
    endtask

    // 12 writes per window, full effect in the sample after return
    task automatic config_all(logic [1:0] w, logic [23:0] pitch, logic key);
        int dummy;
        for (int i = 0; i < N; i++) begin
            if (i > 0 && i % 12 == 0) begin
                end_writes();
                next_frame(dummy);
            end
            host_write(i, pitch, w, key);
        end
        end_writes();
        next_frame(dummy);
    endtask

    initial begin
        int          mix;
        int          s;
        logic [23:0] p;
        logic [25:0] a;
        errors    = 0;
        checks    = 0;
        have_last = 1'b0;
        last_t    = 0;
        reset     = 1'b1;
        cfg_wr    = '0;
        void'($urandom(66784));
        for (int i = 0; i < N; i++) begin
            acc_m[i]     = '0;
            act_pitch[i] = '0;
            act_wave[i]  = 2'd0;
            act_key[i]   = 1'b1;  // first frame clears the ram
            sh_pitch[i]  = '0;
            sh_wave[i]   = 2'd0;
            sh_key[i]    = 1'b0;
        end
        repeat (16) @(posedge sCLK_XVXENVS);
        reset <= 1'b0;

        for (int f = 0; f < 4; f++) begin
            next_frame(mix);
            check_value("mix_sample", 32'(mix), 32'(0));
        end

        // single saw slot, pitch large enough to wrap often
        s = int'($urandom % N);
        p = 24'($urandom) | 24'h400000;
        host_write(s, p, 2'd1, 1'b0);
        end_writes();
        for (int f = 0; f < 24; f++) begin
            next_frame(mix);
        end

        for (int f = 0; f < 200; f++) begin
            random_writes(int'($urandom % 13));
            next_frame(mix);
        end

        config_all(2'd0, 24'd0, 1'b0);
        next_frame(mix);
        check_value("mix_sample", 32'(mix), 32'(0));

        // key-on restart of one saw slot
        s = int'($urandom % N);
        p = 24'($urandom) | 24'h100000;
        host_write(s, p, 2'd1, 1'b0);
        end_writes();
        for (int f = 0; f < 4; f++) begin
            next_frame(mix);
        end
        host_write(s, p, 2'd1, 1'b1);
        end_writes();
        next_frame(mix);
        next_frame(mix);
        check_value("mix_sample", 32'(mix), 32'(-1024));
        a = 26'd0;
        for (int f = 0; f < 3; f++) begin
            a = a + {2'b00, p};
            next_frame(mix);
            check_value("mix_sample", 32'(mix), 32'(int'(a[24:14]) - 1024));
        end

        // write after sample k shows first in sample k+2
        host_write(s, 24'd0, 2'd0, 1'b0);
        end_writes();
        next_frame(mix);
        next_frame(mix);
        check_value("mix_sample", 32'(mix), 32'(0));
        host_write((s + 1) % N, 24'd0, 2'd2, 1'b1);
        end_writes();
        next_frame(mix);
        check_value("mix_sample", 32'(mix), 32'(0));
        next_frame(mix);
        check_value("mix_sample", 32'(mix), 32'(1023));

        // full scale on every slot, then maximum pitch
        config_all(2'd2, 24'd0, 1'b1);
        next_frame(mix);
        check_value("mix_sample", 32'(mix), 32'(N * 1023));
        config_all(2'd3, 24'd0, 1'b1);
        next_frame(mix);
        check_value("mix_sample", 32'(mix), 32'(-N * 1024));
        config_all(2'd2, 24'hFFFFFF, 1'b0);
        for (int f = 0; f < 16; f++) begin
            next_frame(mix);
        end
        config_all(2'd3, 24'hFFFFFF, 1'b0);
        for (int f = 0; f < 16; f++) begin
            next_frame(mix);
        end

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: logic/nco_phase.sv
`timescale 1ns/1ns

module nco_phase #(
    parameter int VOICES = 8,
    parameter int V_OSC  = 4
) (
    input  logic                  sCLK_XVXENVS,
    input  logic                  reset,
    input  osc_pkg::slot_t        cfg_slot,
    input  osc_pkg::slot_cfg_t    slot_cfg,
    output synth_cfg_pkg::phase_t phase,
    output osc_pkg::wave_e        wave,
    output logic                  phase_valid
);

    osc_pkg::slot_t        slot_d1;
    osc_pkg::slot_cfg_t    cfg_d1;
    logic                  in_valid;  // slot_cfg input is live
    logic                  valid_d1;
    synth_cfg_pkg::accum_t ram_q;
    synth_cfg_pkg::accum_t cur_acc;
    synth_cfg_pkg::accum_t next_acc;

    nco_ram #(
        .VOICES (VOICES),
        .V_OSC  (V_OSC)
    ) u_nco_ram (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .we           (valid_d1),
        .write_slot   (slot_d1),
        .d            (next_acc),
        .read_slot    (cfg_slot),
        .q            (ram_q)
    );

    // key-on restarts the slot at zero
    assign cur_acc  = cfg_d1.key_on ? '0 : ram_q;
    assign next_acc = cur_acc + synth_cfg_pkg::accum_t'(cfg_d1.pitch);

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            in_valid    <= 1'b0;
            valid_d1    <= 1'b0;
            phase_valid <= 1'b0;
        end else begin
            in_valid    <= 1'b1;
            valid_d1    <= in_valid;
            phase_valid <= valid_d1;
        end
    end

    // slot and config ride along with the ram read
    always_ff @(posedge sCLK_XVXENVS) begin
        slot_d1 <= cfg_slot;
        cfg_d1  <= slot_cfg;
        phase   <= cur_acc[synth_cfg_pkg::PHASE_LSB +: synth_cfg_pkg::PHASE_W];
        wave    <= cfg_d1.wave;
    end

endmodule

// File: logic/nco_ram.sv
`timescale 1ns/1ns

module nco_ram #(
    parameter int VOICES = 8,
    parameter int V_OSC  = 4
) (
    input  logic                  sCLK_XVXENVS,
    input  logic                  we,
    input  osc_pkg::slot_t        write_slot,
    input  synth_cfg_pkg::accum_t d,
    input  osc_pkg::slot_t        read_slot,
    output synth_cfg_pkg::accum_t q
);

    localparam int N     = VOICES * V_OSC;
    localparam int IDX_W = $clog2(N);

    synth_cfg_pkg::accum_t mem [N];
    logic [IDX_W-1:0]      wr_idx;
    logic [IDX_W-1:0]      rd_idx;

    // flat index, osc fastest
    assign wr_idx = IDX_W'(int'(write_slot.voice) * V_OSC + int'(write_slot.osc));
    assign rd_idx = IDX_W'(int'(read_slot.voice) * V_OSC + int'(read_slot.osc));

    always_ff @(posedge sCLK_XVXENVS) begin
        if (we) begin
            mem[wr_idx] <= d;
        end
        q <= mem[rd_idx];  // registered read
    end

endmodule

// File: logic/osc_pkg.sv
package osc_pkg;

    typedef enum logic [1:0] {
        WAVE_OFF    = 2'd0,
        WAVE_SAW    = 2'd1,
        WAVE_SQUARE = 2'd2,
        WAVE_TRI    = 2'd3
    } wave_e;

    // osc index runs fastest within a voice
    typedef struct packed {
        synth_cfg_pkg::voice_t voice;
        synth_cfg_pkg::osc_t   osc;
    } slot_t;

    // host write, one slot per strobe
    typedef struct packed {
        logic                  valid;
        slot_t                 slot;
        synth_cfg_pkg::pitch_t pitch;
        wave_e                 wave;
        logic                  key_on;
    } cfg_wr_t;

    typedef struct packed {
        synth_cfg_pkg::pitch_t pitch;
        wave_e                 wave;
        logic                  key_on;  // restart accum at zero
    } slot_cfg_t;

endpackage

// File: logic/slot_config.sv
`timescale 1ns/1ns

module slot_config #(
    parameter int VOICES = 8,
    parameter int V_OSC  = 4
) (
    input  logic               sCLK_XVXENVS,
    input  logic               reset,
    input  osc_pkg::cfg_wr_t   cfg_wr,
    input  osc_pkg::slot_t     cur_slot,
    input  logic               frame_start,
    output osc_pkg::slot_t     cfg_slot,
    output osc_pkg::slot_cfg_t slot_cfg
);

    localparam int N     = VOICES * V_OSC;
    localparam int IDX_W = $clog2(N);

    osc_pkg::slot_cfg_t shadow [N];
    osc_pkg::slot_cfg_t active [N];
    osc_pkg::slot_cfg_t cfg_next;
    logic [IDX_W-1:0]   wr_idx;
    logic [IDX_W-1:0]   rd_idx;
    logic               wr_ok;
    logic               first_frame;  // key-on forced while set
    logic               seen_start;
    logic               force_now;

    assign wr_ok  = cfg_wr.valid && (int'(cfg_wr.slot.voice) < VOICES)
                    && (int'(cfg_wr.slot.osc) < V_OSC);
    assign wr_idx = IDX_W'(int'(cfg_wr.slot.voice) * V_OSC + int'(cfg_wr.slot.osc));
    assign rd_idx = IDX_W'(int'(cur_slot.voice) * V_OSC + int'(cur_slot.osc));

    // drop the force once the second frame begins
    assign force_now = first_frame && !(frame_start && seen_start);

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                shadow[i] <= '0;  // wave off, pitch 0
                active[i] <= '0;
            end
            first_frame <= 1'b1;
            seen_start  <= 1'b0;
        end else begin
            if (frame_start) begin
                for (int i = 0; i < N; i++) begin
                    active[i]        <= shadow[i];
                    shadow[i].key_on <= 1'b0;  // pending key-on consumed
                end
                seen_start <= 1'b1;
                if (seen_start) begin
                    first_frame <= 1'b0;
                end
            end
            if (wr_ok) begin
                shadow[wr_idx].pitch  <= cfg_wr.pitch;
                shadow[wr_idx].wave   <= cfg_wr.wave;
                // sticky until the next latch
                shadow[wr_idx].key_on <= cfg_wr.key_on
                                         | (shadow[wr_idx].key_on & !frame_start);
            end
        end
    end

    // slot 0 sees the freshly latched values
    always_comb begin
        cfg_next = frame_start ? shadow[rd_idx] : active[rd_idx];
        if (force_now) begin
            cfg_next.key_on = 1'b1;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        cfg_slot <= cur_slot;
        slot_cfg <= cfg_next;
    end

endmodule

// File: logic/slot_sequencer.sv
`timescale 1ns/1ns

module slot_sequencer #(
    parameter int VOICES = 8,
    parameter int V_OSC  = 4
) (
    input  logic           sCLK_XVXENVS,
    input  logic           reset,
    output osc_pkg::slot_t cur_slot,
    output logic           frame_start,
    output logic           frame_end
);

    localparam synth_cfg_pkg::voice_t LAST_VOICE = synth_cfg_pkg::voice_t'(VOICES - 1);
    localparam synth_cfg_pkg::osc_t   LAST_OSC   = synth_cfg_pkg::osc_t'(V_OSC - 1);

    osc_pkg::slot_t slot_q;

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            slot_q <= '0;
        end else if (slot_q.osc == LAST_OSC) begin
            slot_q.osc <= '0;
            if (slot_q.voice == LAST_VOICE) begin
                slot_q.voice <= '0;  // wrap to slot 0
            end else begin
                slot_q.voice <= slot_q.voice + 1'b1;
            end
        end else begin
            slot_q.osc <= slot_q.osc + 1'b1;
        end
    end

    assign cur_slot    = slot_q;
    assign frame_start = (slot_q.voice == '0) && (slot_q.osc == '0);
    assign frame_end   = (slot_q.voice == LAST_VOICE) && (slot_q.osc == LAST_OSC);

endmodule

// File: logic/synth_cfg_pkg.sv
package synth_cfg_pkg;

    // datapath widths
    localparam int PITCH_W  = 24;
    localparam int ACCUM_W  = 26;
    localparam int PHASE_W  = 11;
    localparam int PHASE_LSB = 14;  // phase = accum[24:14]
    localparam int SAMPLE_W = 12;
    localparam int MIX_W    = 18;   // 32 full-scale slots fit
    localparam int VOICE_W  = 3;
    localparam int OSC_W    = 2;

    // phase increment added once per frame
    typedef logic [PITCH_W-1:0] pitch_t;

    // accumulator wraps modulo 2^26
    typedef logic [ACCUM_W-1:0] accum_t;

    typedef logic [PHASE_W-1:0] phase_t;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef logic signed [MIX_W-1:0] mix_t;

    typedef logic [VOICE_W-1:0] voice_t;

    typedef logic [OSC_W-1:0] osc_t;

endpackage

// File: logic/synth_osc_top.sv
`timescale 1ns/1ns

module synth_osc_top #(
    parameter int VOICES = 8,
    parameter int V_OSC  = 4
) (
    input  logic                sCLK_XVXENVS,
    input  logic                reset,
    input  osc_pkg::cfg_wr_t    cfg_wr,
    output synth_cfg_pkg::mix_t mix_sample,
    output logic                sample_valid
);

    localparam int FE_DELAY = 4;  // config + nco + shaper stages

    osc_pkg::slot_t         cur_slot;
    logic                   frame_start;
    logic                   frame_end;
    osc_pkg::slot_t         cfg_slot;
    osc_pkg::slot_cfg_t     slot_cfg;
    synth_cfg_pkg::phase_t  phase;
    osc_pkg::wave_e         wave;
    logic                   phase_valid;
    synth_cfg_pkg::sample_t sample;
    logic                   sample_strobe;
    logic [FE_DELAY-1:0]    fe_dly;

    slot_sequencer #(.VOICES(VOICES), .V_OSC(V_OSC)) u_slot_sequencer (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cur_slot     (cur_slot),
        .frame_start  (frame_start),
        .frame_end    (frame_end)
    );

    slot_config #(.VOICES(VOICES), .V_OSC(V_OSC)) u_slot_config (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cfg_wr       (cfg_wr),
        .cur_slot     (cur_slot),
        .frame_start  (frame_start),
        .cfg_slot     (cfg_slot),
        .slot_cfg     (slot_cfg)
    );

    nco_phase #(.VOICES(VOICES), .V_OSC(V_OSC)) u_nco_phase (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cfg_slot     (cfg_slot),
        .slot_cfg     (slot_cfg),
        .phase        (phase),
        .wave         (wave),
        .phase_valid  (phase_valid)
    );

    wave_shaper u_wave_shaper (
        .sCLK_XVXENVS  (sCLK_XVXENVS),
        .reset         (reset),
        .phase         (phase),
        .wave          (wave),
        .phase_valid   (phase_valid),
        .sample        (sample),
        .sample_strobe (sample_strobe)
    );

    // frame_end tag follows its slot down the pipe
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            fe_dly <= '0;
        end else begin
            fe_dly <= {fe_dly[FE_DELAY-2:0], frame_end};
        end
    end

    voice_mixer u_voice_mixer (
        .sCLK_XVXENVS  (sCLK_XVXENVS),
        .reset         (reset),
        .sample        (sample),
        .sample_strobe (sample_strobe),
        .last_in_frame (fe_dly[FE_DELAY-1]),
        .mix_sample    (mix_sample),
        .sample_valid  (sample_valid)
    );

endmodule

// File: logic/voice_mixer.sv
`timescale 1ns/1ns

module voice_mixer (
    input  logic                   sCLK_XVXENVS,
    input  logic                   reset,
    input  synth_cfg_pkg::sample_t sample,
    input  logic                   sample_strobe,
    input  logic                   last_in_frame,
    output synth_cfg_pkg::mix_t    mix_sample,
    output logic                   sample_valid
);

    synth_cfg_pkg::mix_t sum;
    synth_cfg_pkg::mix_t sample_ext;
    synth_cfg_pkg::mix_t sum_next;

    assign sample_ext = synth_cfg_pkg::mix_t'(sample);  // sign extend
    assign sum_next   = sum + sample_ext;

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            sum          <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= sample_strobe && last_in_frame;
            if (sample_strobe) begin
                // last slot closes the frame
                sum <= last_in_frame ? '0 : sum_next;
            end
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (sample_strobe && last_in_frame) begin
            mix_sample <= sum_next;
        end
    end

endmodule

// File: logic/wave_shaper.sv
`timescale 1ns/1ns

module wave_shaper (
    input  logic                   sCLK_XVXENVS,
    input  logic                   reset,
    input  synth_cfg_pkg::phase_t  phase,
    input  osc_pkg::wave_e         wave,
    input  logic                   phase_valid,
    output synth_cfg_pkg::sample_t sample,
    output logic                   sample_strobe
);

    logic [9:0]             tri_q;
    synth_cfg_pkg::sample_t tri_2q;   // 2q, 0..2046
    synth_cfg_pkg::sample_t shaped;

    assign tri_q  = phase[9:0];
    assign tri_2q = synth_cfg_pkg::sample_t'({1'b0, tri_q, 1'b0});

    always_comb begin
        case (wave)
            osc_pkg::WAVE_SAW: begin
                shaped = synth_cfg_pkg::sample_t'({1'b0, phase}) - 12'sd1024;
            end
            osc_pkg::WAVE_SQUARE: begin
                shaped = phase[10] ? -12'sd1024 : 12'sd1023;
            end
            osc_pkg::WAVE_TRI: begin
                // rising half then falling half
                shaped = phase[10] ? (12'sd1023 - tri_2q) : (tri_2q - 12'sd1024);
            end
            default: begin
                shaped = '0;  // off
            end
        endcase
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            sample_strobe <= 1'b0;
        end else begin
            sample_strobe <= phase_valid;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        sample <= shaped;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f compile.f --top-module tb_synth_osc -o tb_synth_osc \
    && ./obj_dir/tb_synth_osc > sim.log 2>&1 \
    || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
